//--- sim/gfx_mem_cases.txt
# columns: port op address data expected, all hex; ports C cpu, V video, B both, I instruction
# on R lines data bits 1 and 0 drive hblank and vblank, on W lines data is the write word
C W 0000 1234 0000
C W 1FFF BEEF 0000
C W 0ABC 5A5A 0000
C R 0000 0000 1234
C R 1FFF 0000 BEEF
I R 0000 0000 1234
I R 1FFF 0000 BEEF
I R 0ABC 0000 5A5A
C W 2000 A001 0000
C W 23FF A002 0000
C W 2400 A003 0000
C W 43FF A004 0000
C R 2000 0000 A001
C R 43FF 0000 A004
V R 23FF 0000 A002
V R 2400 0000 A003
V R 43FF 0000 A004
B R 2000 0000 A001
B R 43FF 0000 A004
B R 2400 0000 A003
C W 4802 01FF 0000
C R 4802 0000 00FF
C W 4801 FFFF 0000
C R 4801 0000 007F
C R 4800 0000 0000
C R 4800 0001 0100
C R 4800 0002 0200
C R 4800 0003 0300
C W 4400 FFFF 0000
C R 4400 0000 0000
C W 9000 FFFF 0000
C R 9000 0000 0000

//--- sim/gfx_mem_checker.sv
`timescale 1ns/1ps

module gfx_mem_checker import gfx_mem_pkg::*; (
	input  logic                    clk,
	input  logic                    cpu_stb,
	input  logic                    cpu_we,
	input  logic [addr_w-1:0]       cpu_adr,
	input  logic [data_w-1:0]       cpu_dat_r,
	input  logic                    cpu_ack,
	input  logic                    vid_stb,
	input  logic [data_w-1:0]       vid_dat_r,
	input  logic                    vid_ack,
	input  logic [data_w-1:0]       instruction,
	input  logic [priority_w-1:0]   sprite_priority,
	input  logic [brightness_w-1:0] brightness,
	// Expectations from the testbench
	input  logic                    pc_check,
	input  int                      case_num,
	input  logic [data_w-1:0]       exp_data,
	output int                      pass_count,
	output int                      fail_count
);

	logic pc_pending = 1'b0;
	int case_errors = 0;

	initial begin
		pass_count = 0;
		fail_count = 0;
	end

	task automatic compare(input string name, input logic [data_w-1:0] expected,
			input logic [data_w-1:0] actual);
		if (actual !== expected) begin
			$display("Fail case %0d: %s expected %h, got %h", case_num, name, expected, actual);
			case_errors++;
		end
	endtask

	//////////////////////////////
	// Sampling at the falling edge
	//////////////////////////////

	always @(negedge clk) begin
		// Instruction word lags pc_addr by one cycle
		if (pc_pending)
			compare("instruction", exp_data, instruction);
		pc_pending = pc_check;
		if (cpu_ack && cpu_stb && !cpu_we) begin
			compare("cpu_dat_r", exp_data, cpu_dat_r);
			if (cpu_adr == brightness_addr)
				compare("brightness", exp_data, {{(data_w-brightness_w){1'b0}}, brightness});
			if (cpu_adr == priority_addr)
				compare("sprite_priority", exp_data,
					{{(data_w-priority_w){1'b0}}, sprite_priority});
		end
		if (vid_ack && vid_stb)
			compare("vid_dat_r", exp_data, vid_dat_r);
	end

	task automatic report_timeout(input string port_name);
		$display("case %0d: no acknowledge on %s port", case_num, port_name);
		case_errors++;
	endtask

	// One line per finished case
	task automatic end_case(input string label);
		if (case_errors == 0) begin
			$display("case %0d: %s ok", case_num, label);
			pass_count++;
		end else begin
			$display("case %0d: %s failed with %0d error(s)", case_num, label, case_errors);
			fail_count++;
		end
		case_errors = 0;
	endtask

endmodule

//--- sim/gfx_mem_properties.sv
`timescale 1ns/1ps

module gfx_mem_properties (
	input logic clk,
	input logic rst,
	input logic vc_cyc,
	input logic vc_stb,
	input logic vc_ack,
	input logic vid_cyc,
	input logic vid_stb,
	input logic vid_ack,
	input logic vr_en
);

	int failures = 0;

	//////////////////////////////
	// Arbiter rules
	//////////////////////////////

	// A waiting master is served after one other access at most
	cpu_ack_bound: assert property (@(posedge clk) disable iff (!rst)
		(vc_cyc && vc_stb && !vc_ack) |-> ##[1:4] vc_ack)
		else begin
			$error("cpu side request not acknowledged within four cycles");
			failures++;
		end

	vid_ack_bound: assert property (@(posedge clk) disable iff (!rst)
		(vid_cyc && vid_stb && !vid_ack) |-> ##[1:4] vid_ack)
		else begin
			$error("video side request not acknowledged within four cycles");
			failures++;
		end

	cpu_ack_requested: assert property (@(posedge clk) disable iff (!rst)
		vc_ack |-> (vc_cyc && vc_stb))
		else begin
			$error("cpu side acknowledged without an open cycle");
			failures++;
		end

	vid_ack_requested: assert property (@(posedge clk) disable iff (!rst)
		vid_ack |-> (vid_cyc && vid_stb))
		else begin
			$error("video side acknowledged without an open cycle");
			failures++;
		end

	// One RAM strobe per grant, then the ack
	en_single: assert property (@(posedge clk) disable iff (!rst)
		vr_en |=> (!vr_en && (vc_ack || vid_ack)))
		else begin
			$error("video RAM enable not a single pulse followed by an ack");
			failures++;
		end

endmodule

bind vram_arbiter gfx_mem_properties i_gfx_mem_properties (.*);

//--- sim/tb_gfx_mem.sv
`timescale 1ns/1ps

module tb_gfx_mem import gfx_mem_pkg::*; ();

	localparam int ack_limit = 20;
	localparam int max_cases = 256;
	localparam string cases_file = "sim/gfx_mem_cases.txt";

	logic clk;
	logic rst;
	logic cpu_cyc;
	logic cpu_stb;
	logic cpu_we;
	logic [addr_w-1:0] cpu_adr;
	logic [data_w-1:0] cpu_dat_w;
	logic [data_w-1:0] cpu_dat_r;
	logic cpu_ack;
	logic vid_cyc;
	logic vid_stb;
	logic [addr_w-1:0] vid_adr;
	logic [data_w-1:0] vid_dat_r;
	logic vid_ack;
	logic [addr_w-1:0] pc_addr;
	logic [data_w-1:0] instruction;
	logic hblank;
	logic vblank;
	logic [priority_w-1:0] sprite_priority;
	logic [brightness_w-1:0] brightness;

	logic pc_check;
	int case_num;
	logic [data_w-1:0] exp_data;
	int pass_count;
	int fail_count;

	gfx_mem_top i_gfx_mem_top (.*);

	gfx_mem_checker i_gfx_mem_checker (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	//////////////////////////////
	// Bus access
	//////////////////////////////

	// Starts just after an edge, returns just after the edge following the last ack
	task automatic run_access(input bit use_cpu, input bit use_vid, input bit write,
			input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
			output bit timed_out);
		bit cpu_wait;
		bit vid_wait;
		bit cpu_drop;
		bit vid_drop;
		cpu_wait = use_cpu;
		vid_wait = use_vid;
		cpu_drop = 1'b0;
		vid_drop = 1'b0;
		timed_out = 1'b0;
		if (use_cpu) begin
			cpu_cyc = 1'b1;
			cpu_stb = 1'b1;
			cpu_we = write;
			cpu_adr = addr;
			cpu_dat_w = data;
		end
		if (use_vid) begin
			vid_cyc = 1'b1;
			vid_stb = 1'b1;
			vid_adr = addr;
		end
		for (int n = 0; n < ack_limit && (cpu_wait || vid_wait); n++) begin
			@(posedge clk);
			#1;
			// Master drops its strobe in the cycle after its ack
			if (cpu_drop) begin
				cpu_cyc = 1'b0;
				cpu_stb = 1'b0;
				cpu_drop = 1'b0;
			end
			if (vid_drop) begin
				vid_cyc = 1'b0;
				vid_stb = 1'b0;
				vid_drop = 1'b0;
			end
			if (cpu_wait && cpu_ack) begin
				cpu_wait = 1'b0;
				cpu_drop = 1'b1;
			end
			if (vid_wait && vid_ack) begin
				vid_wait = 1'b0;
				vid_drop = 1'b1;
			end
		end
		if (cpu_wait)
			i_gfx_mem_checker.report_timeout("cpu");
		if (vid_wait)
			i_gfx_mem_checker.report_timeout("video");
		timed_out = cpu_wait || vid_wait;
		@(posedge clk);
		#1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		vid_cyc = 1'b0;
		vid_stb = 1'b0;
	endtask

	// Fetch latency is fixed at one cycle
	task automatic fetch_instruction(input logic [addr_w-1:0] addr);
		pc_addr = addr;
		pc_check = 1'b1;
		@(posedge clk);
		#1;
		pc_check = 1'b0;
		@(posedge clk);
		#1;
	endtask

	//////////////////////////////
	// Case file
	//////////////////////////////

	initial begin
		int fd;
		int status;
		int file_errors;
		int assert_failures;
		int unsigned lcg_state;
		bit timed_out;
		string line;
		byte port_c;
		byte op_c;
		logic [addr_w-1:0] addr_v;
		logic [data_w-1:0] data_v;
		logic [data_w-1:0] exp_v;

		rst = 1'b0;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_adr = '0;
		cpu_dat_w = '0;
		vid_cyc = 1'b0;
		vid_stb = 1'b0;
		vid_adr = '0;
		pc_addr = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		pc_check = 1'b0;
		case_num = 0;
		exp_data = '0;
		file_errors = 0;
		timed_out = 1'b0;
		lcg_state = 74;

		repeat (16) @(posedge clk);
		#1;
		rst = 1'b1;

		fd = $fopen(cases_file, "r");
		if (fd == 0) begin
			$display("could not open the case file %s", cases_file);
			file_errors++;
		end
		while (fd != 0 && !$feof(fd) && !timed_out && case_num < max_cases) begin
			line = "";
			status = $fgets(line, fd);
			if (status == 0 || line.len() < 9 || line.getc(0) == "#")
				continue;
			status = $sscanf(line, "%c %c %h %h %h", port_c, op_c, addr_v, data_v, exp_v);
			if (status != 5) begin
				$display("case line could not be parsed: %s", line);
				file_errors++;
				continue;
			end

			// Random idle gap of 0 to 3 cycles
			lcg_state = lcg_next(lcg_state);
			repeat ((lcg_state >> 16) % 4) begin
				@(posedge clk);
				#1;
			end

			case_num = case_num + 1;
			exp_data = exp_v;
			if (op_c == "R") begin
				hblank = data_v[1];
				vblank = data_v[0];
			end
			case (port_c)
				"C": run_access(1'b1, 1'b0, op_c == "W", addr_v, data_v, timed_out);
				"V": run_access(1'b0, 1'b1, 1'b0, addr_v, data_v, timed_out);
				"B": run_access(1'b1, 1'b1, 1'b0, addr_v, data_v, timed_out);
				"I": fetch_instruction(addr_v);
				default: begin
					$display("unknown port letter in case line: %s", line);
					file_errors++;
				end
			endcase
			i_gfx_mem_checker.end_case($sformatf("%c %c %h", port_c, op_c, addr_v));
		end
		if (fd != 0)
			$fclose(fd);

		assert_failures = i_gfx_mem_top.i_vram_arbiter.i_gfx_mem_properties.failures;
		$display("%0d cases passed, %0d cases failed, %0d assertion failures",
			pass_count, fail_count, assert_failures);
		if (fail_count == 0 && file_errors == 0 && assert_failures == 0 && !timed_out
				&& pass_count > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
src/gfx_mem_pkg.sv
src/mem_map_decoder.sv
src/program_memory.sv
src/video_ram.sv
src/vram_arbiter.sv
src/gfx_mem_top.sv
sim/gfx_mem_properties.sv
sim/gfx_mem_checker.sv
sim/tb_gfx_mem.sv

//--- src/gfx_mem_pkg.sv
package gfx_mem_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	localparam int addr_w = 16;
	localparam int data_w = 16;

	// Program memory, word addressed from zero
	localparam int prog_words = 8192;
	localparam int prog_addr_w = 13;

	//////////////////////////////
	// Address map
	//////////////////////////////

	// Sprite object table, then tile data, in one video RAM
	localparam logic [addr_w-1:0] sprite_base = 16'h2000;
	localparam logic [addr_w-1:0] tile_base = 16'h2400;
	localparam logic [addr_w-1:0] palette_base = 16'h4400;

	// Video RAM index is address minus sprite_base
	localparam int vram_words = 9216;
	localparam int vram_addr_w = 14;

	// Miscellaneous registers
	localparam logic [addr_w-1:0] status_addr = 16'h4800;
	localparam logic [addr_w-1:0] priority_addr = 16'h4801;
	localparam logic [addr_w-1:0] brightness_addr = 16'h4802;

	//////////////////////////////
	// Register fields
	//////////////////////////////

	localparam int priority_w = 7;
	localparam int brightness_w = 8;

	localparam logic [priority_w-1:0] priority_init = '0;
	localparam logic [brightness_w-1:0] brightness_init = '0;

	// Status word bit positions, others read zero
	localparam int status_hblank_bit = 9;
	localparam int status_vblank_bit = 8;

endpackage

//--- src/gfx_mem_top.sv
`timescale 1ns/1ps

module gfx_mem_top import gfx_mem_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	// CPU data port
	input  logic                    cpu_cyc,
	input  logic                    cpu_stb,
	input  logic                    cpu_we,
	input  logic [addr_w-1:0]       cpu_adr,
	input  logic [data_w-1:0]       cpu_dat_w,
	output logic [data_w-1:0]       cpu_dat_r,
	output logic                    cpu_ack,
	// Video fetch port
	input  logic                    vid_cyc,
	input  logic                    vid_stb,
	input  logic [addr_w-1:0]       vid_adr,
	output logic [data_w-1:0]       vid_dat_r,
	output logic                    vid_ack,
	// Instruction port
	input  logic [addr_w-1:0]       pc_addr,
	output logic [data_w-1:0]       instruction,
	// Graphics status and control
	input  logic                    hblank,
	input  logic                    vblank,
	output logic [priority_w-1:0]   sprite_priority,
	output logic [brightness_w-1:0] brightness
);

	logic pm_en;
	logic pm_we;
	logic [prog_addr_w-1:0] pm_addr;
	logic [data_w-1:0] pm_wdata;
	logic [data_w-1:0] pm_rdata;

	logic vc_cyc;
	logic vc_stb;
	logic vc_we;
	logic [vram_addr_w-1:0] vc_adr;
	logic [data_w-1:0] vc_dat_w;
	logic [data_w-1:0] vc_dat_r;
	logic vc_ack;

	logic vr_en;
	logic vr_we;
	logic [vram_addr_w-1:0] vr_addr;
	logic [data_w-1:0] vr_wdata;
	logic [data_w-1:0] vr_rdata;

	//////////////////////////////
	// CPU decode
	//////////////////////////////

	mem_map_decoder i_mem_map_decoder (
		.clk             (clk),
		.rst             (rst),
		.cpu_cyc         (cpu_cyc),
		.cpu_stb         (cpu_stb),
		.cpu_we          (cpu_we),
		.cpu_adr         (cpu_adr),
		.cpu_dat_w       (cpu_dat_w),
		.cpu_dat_r       (cpu_dat_r),
		.cpu_ack         (cpu_ack),
		.hblank          (hblank),
		.vblank          (vblank),
		.sprite_priority (sprite_priority),
		.brightness      (brightness),
		.pm_en           (pm_en),
		.pm_we           (pm_we),
		.pm_addr         (pm_addr),
		.pm_wdata        (pm_wdata),
		.pm_rdata        (pm_rdata),
		.vc_cyc          (vc_cyc),
		.vc_stb          (vc_stb),
		.vc_we           (vc_we),
		.vc_adr          (vc_adr),
		.vc_dat_w        (vc_dat_w),
		.vc_dat_r        (vc_dat_r),
		.vc_ack          (vc_ack)
	);

	// Instruction fetch uses the low address bits only
	program_memory i_program_memory (
		.clk     (clk),
		.a_en    (pm_en),
		.a_we    (pm_we),
		.a_addr  (pm_addr),
		.a_wdata (pm_wdata),
		.a_rdata (pm_rdata),
		.b_addr  (pc_addr[prog_addr_w-1:0]),
		.b_rdata (instruction)
	);

	//////////////////////////////
	// Shared video RAM
	//////////////////////////////

	vram_arbiter i_vram_arbiter (
		.clk       (clk),
		.rst       (rst),
		.vc_cyc    (vc_cyc),
		.vc_stb    (vc_stb),
		.vc_we     (vc_we),
		.vc_adr    (vc_adr),
		.vc_dat_w  (vc_dat_w),
		.vc_dat_r  (vc_dat_r),
		.vc_ack    (vc_ack),
		.vid_cyc   (vid_cyc),
		.vid_stb   (vid_stb),
		.vid_adr   (vid_adr),
		.vid_dat_r (vid_dat_r),
		.vid_ack   (vid_ack),
		.vr_en     (vr_en),
		.vr_we     (vr_we),
		.vr_addr   (vr_addr),
		.vr_wdata  (vr_wdata),
		.vr_rdata  (vr_rdata)
	);

	video_ram i_video_ram (
		.clk   (clk),
		.en    (vr_en),
		.we    (vr_we),
		.addr  (vr_addr),
		.wdata (vr_wdata),
		.rdata (vr_rdata)
	);

endmodule

//--- src/mem_map_decoder.sv
`timescale 1ns/1ps

module mem_map_decoder import gfx_mem_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	// CPU data port
	input  logic                    cpu_cyc,
	input  logic                    cpu_stb,
	input  logic                    cpu_we,
	input  logic [addr_w-1:0]       cpu_adr,
	input  logic [data_w-1:0]       cpu_dat_w,
	output logic [data_w-1:0]       cpu_dat_r,
	output logic                    cpu_ack,
	// Graphics status and control
	input  logic                    hblank,
	input  logic                    vblank,
	output logic [priority_w-1:0]   sprite_priority,
	output logic [brightness_w-1:0] brightness,
	// Program memory data port
	output logic                    pm_en,
	output logic                    pm_we,
	output logic [prog_addr_w-1:0]  pm_addr,
	output logic [data_w-1:0]       pm_wdata,
	input  logic [data_w-1:0]       pm_rdata,
	// CPU side of the video RAM arbiter
	output logic                    vc_cyc,
	output logic                    vc_stb,
	output logic                    vc_we,
	output logic [vram_addr_w-1:0]  vc_adr,
	output logic [data_w-1:0]       vc_dat_w,
	input  logic [data_w-1:0]       vc_dat_r,
	input  logic                    vc_ack
);

	logic prog_hit;
	logic vid_hit;
	logic issue;
	logic busy;
	logic sel_prog;
	logic [addr_w-1:0] vid_index;
	logic [data_w-1:0] status_word;
	logic [data_w-1:0] reg_rdata;

	//////////////////////////////
	// Region decode
	//////////////////////////////

	assign prog_hit = cpu_adr < sprite_base;
	// Sprite and tile data share one RAM, so one range test covers both
	assign vid_hit = (cpu_adr >= sprite_base) && (cpu_adr < palette_base);

	// Local accesses only; video cycles are handled by the arbiter
	assign issue = cpu_cyc && cpu_stb && !busy && !vid_hit;

	// Program memory sees the access for the issue cycle only
	assign pm_en = issue && prog_hit;
	assign pm_we = cpu_we;
	assign pm_addr = cpu_adr[prog_addr_w-1:0];
	assign pm_wdata = cpu_dat_w;

	// Video cycle is held by the CPU itself until the arbiter acks
	assign vid_index = cpu_adr - sprite_base;
	assign vc_cyc = cpu_cyc && vid_hit;
	assign vc_stb = cpu_stb && vid_hit;
	assign vc_we = cpu_we;
	assign vc_adr = vid_index[vram_addr_w-1:0];
	assign vc_dat_w = cpu_dat_w;

	//////////////////////////////
	// Misc registers
	//////////////////////////////

	always_comb begin
		status_word = '0;
		status_word[status_hblank_bit] = hblank;
		status_word[status_vblank_bit] = vblank;
	end

	// Busy is high exactly in the ack cycle of a local access
	always_ff @(posedge clk) begin
		if (!rst) begin
			busy <= 1'b0;
			brightness <= brightness_init;
			sprite_priority <= priority_init;
		end else begin
			busy <= issue;
			if (issue && cpu_we) begin
				// Writes keep only the low bits
				if (cpu_adr == brightness_addr)
					brightness <= cpu_dat_w[brightness_w-1:0];
				if (cpu_adr == priority_addr)
					sprite_priority <= cpu_dat_w[priority_w-1:0];
			end
		end
	end

	// Read data captured at issue, palette and unmapped read zero
	always_ff @(posedge clk) begin
		if (issue) begin
			sel_prog <= prog_hit;
			case (cpu_adr)
				status_addr:     reg_rdata <= status_word;
				priority_addr:   reg_rdata <= {{(data_w-priority_w){1'b0}}, sprite_priority};
				brightness_addr: reg_rdata <= {{(data_w-brightness_w){1'b0}}, brightness};
				default:         reg_rdata <= '0;
			endcase
		end
	end

	//////////////////////////////
	// Response
	//////////////////////////////

	assign cpu_ack = busy || vc_ack;
	assign cpu_dat_r = vid_hit ? vc_dat_r : (sel_prog ? pm_rdata : reg_rdata);

endmodule

//--- src/program_memory.sv
`timescale 1ns/1ps

module program_memory import gfx_mem_pkg::*; (
	input  logic                   clk,
	// Data port, read/write
	input  logic                   a_en,
	input  logic                   a_we,
	input  logic [prog_addr_w-1:0] a_addr,
	input  logic [data_w-1:0]      a_wdata,
	output logic [data_w-1:0]      a_rdata,
	// Instruction fetch port, read only
	input  logic [prog_addr_w-1:0] b_addr,
	output logic [data_w-1:0]      b_rdata
);

	logic [data_w-1:0] mem [prog_words];

	//////////////////////////////
	// Port A
	//////////////////////////////

	// Read-first, a write returns the old word
	always_ff @(posedge clk) begin
		if (a_en) begin
			if (a_we)
				mem[a_addr] <= a_wdata;
			a_rdata <= mem[a_addr];
		end
	end

	//////////////////////////////
	// Port B
	//////////////////////////////

	// Fetch every cycle, new data visible after the write edge
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

endmodule

//--- src/video_ram.sv
`timescale 1ns/1ps

module video_ram import gfx_mem_pkg::*; (
	input  logic                   clk,
	input  logic                   en,
	input  logic                   we,
	input  logic [vram_addr_w-1:0] addr,
	input  logic [data_w-1:0]      wdata,
	output logic [data_w-1:0]      rdata
);

	// Sprite object table first, tile data after it
	logic [data_w-1:0] mem [vram_words];

	// Single port, read-first
	// rdata holds its value while en is low
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

//--- src/vram_arbiter.sv
`timescale 1ns/1ps

module vram_arbiter import gfx_mem_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	// CPU side master from the decoder
	input  logic                   vc_cyc,
	input  logic                   vc_stb,
	input  logic                   vc_we,
	input  logic [vram_addr_w-1:0] vc_adr,
	input  logic [data_w-1:0]      vc_dat_w,
	output logic [data_w-1:0]      vc_dat_r,
	output logic                   vc_ack,
	// Video fetch master, read only
	input  logic                   vid_cyc,
	input  logic                   vid_stb,
	input  logic [addr_w-1:0]      vid_adr,
	output logic [data_w-1:0]      vid_dat_r,
	output logic                   vid_ack,
	// Video RAM
	output logic                   vr_en,
	output logic                   vr_we,
	output logic [vram_addr_w-1:0] vr_addr,
	output logic [data_w-1:0]      vr_wdata,
	input  logic [data_w-1:0]      vr_rdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_ack
	} arb_state_t;

	arb_state_t state;
	logic owner_vid;
	logic cpu_open;
	logic vid_open;
	logic grant_ok;
	logic pick_vid;
	logic [addr_w-1:0] vid_index;

	assign vid_index = vid_adr - sprite_base;

	//////////////////////////////
	// Request selection
	//////////////////////////////

	// The master in its ack cycle still holds stb, not a new request
	assign cpu_open = vc_cyc && vc_stb && !(state == st_ack && !owner_vid);
	assign vid_open = vid_cyc && vid_stb && !(state == st_ack && owner_vid);

	// Grant from idle, or straight from ack to the other master
	assign grant_ok = (state == st_idle || state == st_ack) && (cpu_open || vid_open);

	// Tie goes to the master not granted last
	assign pick_vid = vid_open && (!cpu_open || !owner_vid);

	//////////////////////////////
	// FSM
	//////////////////////////////

	// owner_vid low after reset, so video wins the first tie
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			owner_vid <= 1'b0;
			vr_en <= 1'b0;
			vr_we <= 1'b0;
		end else begin
			vr_en <= 1'b0;
			vr_we <= 1'b0;
			case (state)
				st_idle, st_ack: begin
					if (grant_ok) begin
						state <= st_access;
						owner_vid <= pick_vid;
						vr_en <= 1'b1;
						vr_we <= !pick_vid && vc_we;
					end else begin
						state <= st_idle;
					end
				end
				st_access: state <= st_ack;
				default:   state <= st_idle;
			endcase
		end
	end

	// RAM address and data for the granted master
	always_ff @(posedge clk) begin
		if (grant_ok) begin
			vr_addr <= pick_vid ? vid_index[vram_addr_w-1:0] : vc_adr;
			vr_wdata <= vc_dat_w;
		end
	end

	// One ack cycle, to the owner only
	assign vc_ack = (state == st_ack) && !owner_vid;
	assign vid_ack = (state == st_ack) && owner_vid;
	assign vc_dat_r = vr_rdata;
	assign vid_dat_r = vr_rdata;

endmodule
